//--- hw/mem_pkg.sv
package mem_pkg;

	// widths of the memory system
	localparam int ADDR_W      = 20;
	localparam int LINE_W      = 128;
	localparam int WORD_W      = 32;
	localparam int OFFS_W      = 4;
	localparam int IDX_W       = ADDR_W - OFFS_W;
	localparam int BE_W        = LINE_W / 8;
	localparam int CFG_ADDR_W  = 2;
	localparam int LAT_W       = 3;

	// the store covers the full 20-bit byte address range
	localparam int MEM_LINES   = 65536;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [IDX_W-1:0]      line_idx_t;
	typedef logic [BE_W-1:0]       byte_en_t;
	typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
	typedef logic [LAT_W-1:0]      lat_t;

	// configuration register map
	localparam cfg_addr_t REG_LATENCY     = 2'd0;
	localparam cfg_addr_t REG_READ_CNT    = 2'd1;
	localparam cfg_addr_t REG_WORD_WR_CNT = 2'd2;
	localparam cfg_addr_t REG_BYTE_WR_CNT = 2'd3;

	// access controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RESP
	} ctrl_state_e;

endpackage

//--- hw/line_ram.sv
`timescale 1ns/1ps

module line_ram (
	input  logic               clk,
	input  logic               en_i,
	input  logic               we_i,
	input  mem_pkg::line_idx_t idx_i,
	input  mem_pkg::byte_en_t  be_i,
	input  mem_pkg::line_t     wdata_i,
	output mem_pkg::line_t     rdata_o
);
	import mem_pkg::*;

	// one entry per 16-byte line
	line_t mem_q [MEM_LINES];

	// write port, only the enabled bytes of the line change
	always_ff @(posedge clk) begin
		if (en_i && we_i) begin
			for (int b = 0; b < BE_W; b++) begin
				if (be_i[b]) begin
					mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

	// registered read
	// the output keeps its value while en_i is low and the controller relies on that
	// during the latency countdown
	always_ff @(posedge clk) begin
		if (en_i && !we_i) begin
			rdata_o <= mem_q[idx_i];
		end
	end

endmodule

//--- hw/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
	input  logic               clk,
	input  logic               arst_n_i,

	// read request channel
	input  logic               rd_valid_i,
	input  mem_pkg::addr_t     rd_addr_i,
	output logic               rd_ready_o,

	// write channel
	input  logic               wr_valid_i,
	input  mem_pkg::addr_t     wr_addr_i,
	input  mem_pkg::word_t     wr_data_i,
	input  logic               wr_byte_i,
	output logic               wr_ready_o,

	// read response channel
	output logic               rd_resp_valid_o,
	output mem_pkg::line_t     rd_resp_data_o,
	output mem_pkg::addr_t     rd_resp_addr_o,
	input  logic               rd_resp_ready_i,

	// line store
	output logic               ram_en_o,
	output logic               ram_we_o,
	output mem_pkg::line_idx_t ram_idx_o,
	output mem_pkg::byte_en_t  ram_be_o,
	output mem_pkg::line_t     ram_wdata_o,
	input  mem_pkg::line_t     ram_rdata_i,

	// register block
	input  mem_pkg::lat_t      latency_i,
	output logic               rd_done_o,
	output logic               word_wr_done_o,
	output logic               byte_wr_done_o
);
	import mem_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	lat_t        lat_cnt_q;
	line_t       resp_data_q;
	addr_t       resp_addr_q;

	logic        idle;
	logic        wr_go;
	logic        rd_go;
	logic        wait_done;
	byte_en_t    word_be;
	byte_en_t    byte_be;

	assign idle = (state_q == ST_IDLE);

	// a pending write hides the read ready, so writes win in idle
	assign wr_ready_o = idle;
	assign rd_ready_o = idle && !wr_valid_i;

	assign wr_go = wr_valid_i && wr_ready_o;
	assign rd_go = rd_valid_i && rd_ready_o;

	assign wait_done = (state_q == ST_WAIT) && (lat_cnt_q == '0);

	// enables for the addressed word or the single addressed byte
	assign word_be = byte_en_t'(4'hF) << {wr_addr_i[3:2], 2'b00};
	assign byte_be = byte_en_t'(1'b1) << wr_addr_i[OFFS_W-1:0];

	// the store is driven straight from the accepted request, so a write
	// lands on its acceptance edge and a read is registered on that same edge
	assign ram_en_o    = wr_go || rd_go;
	assign ram_we_o    = wr_go;
	assign ram_idx_o   = wr_go ? wr_addr_i[ADDR_W-1:OFFS_W] : rd_addr_i[ADDR_W-1:OFFS_W];
	assign ram_be_o    = wr_byte_i ? byte_be : word_be;
	assign ram_wdata_o = wr_byte_i ? {BE_W{wr_data_i[7:0]}} : {(LINE_W/WORD_W){wr_data_i}};

	assign rd_resp_valid_o = (state_q == ST_RESP);
	assign rd_resp_data_o  = resp_data_q;
	assign rd_resp_addr_o  = resp_addr_q;

	// event pulses for the counters
	assign word_wr_done_o = wr_go && !wr_byte_i;
	assign byte_wr_done_o = wr_go && wr_byte_i;
	assign rd_done_o      = rd_resp_valid_o && rd_resp_ready_i;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			ST_IDLE: begin
				if (rd_go) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (lat_cnt_q == '0) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				// hold until the response is taken
				if (rd_resp_ready_i) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= ST_IDLE;
			lat_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// latency is sampled once per read so later register writes do not affect it
			if (rd_go) begin
				lat_cnt_q <= latency_i;
			end else if (state_q == ST_WAIT && lat_cnt_q != '0) begin
				lat_cnt_q <= lat_cnt_q - 1'b1;
			end
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (rd_go) begin
			resp_addr_q <= rd_addr_i;
		end
		if (wait_done) begin
			resp_data_q <= ram_rdata_i;
		end
	end

endmodule

//--- hw/mem_cfg_regs.sv
`timescale 1ns/1ps

module mem_cfg_regs (
	input  logic               clk,
	input  logic               arst_n_i,

	// configuration bus
	input  logic               cfg_wr_en_i,
	input  mem_pkg::cfg_addr_t cfg_addr_i,
	input  mem_pkg::word_t     cfg_wdata_i,
	output mem_pkg::word_t     cfg_rdata_o,

	// controller side
	output mem_pkg::lat_t      latency_o,
	input  logic               rd_done_i,
	input  logic               word_wr_done_i,
	input  logic               byte_wr_done_i
);
	import mem_pkg::*;

	localparam int NUM_CNT = 3;

	lat_t               latency_q;
	word_t              cnt_q [NUM_CNT];
	logic [NUM_CNT-1:0] evt;
	logic [NUM_CNT-1:0] cnt_clr;

	// counter i sits at register address REG_READ_CNT + i
	assign evt = {byte_wr_done_i, word_wr_done_i, rd_done_i};

	always_comb begin
		for (int i = 0; i < NUM_CNT; i++) begin
			cnt_clr[i] = cfg_wr_en_i && (cfg_addr_i == REG_READ_CNT + cfg_addr_t'(i));
		end
	end

	assign latency_o = latency_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			latency_q <= '0;
		end else if (cfg_wr_en_i && cfg_addr_i == REG_LATENCY) begin
			latency_q <= cfg_wdata_i[LAT_W-1:0];
		end
	end

	// a clear in the same cycle as an event wins and that event is not counted
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_CNT; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				if (cnt_clr[i]) begin
					cnt_q[i] <= '0;
				end else if (evt[i]) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// read data follows the address without a clock
	always_comb begin
		unique case (cfg_addr_i)
			REG_LATENCY:     cfg_rdata_o = word_t'(latency_q);
			REG_READ_CNT:    cfg_rdata_o = cnt_q[0];
			REG_WORD_WR_CNT: cfg_rdata_o = cnt_q[1];
			REG_BYTE_WR_CNT: cfg_rdata_o = cnt_q[2];
			default:         cfg_rdata_o = '0;
		endcase
	end

endmodule

//--- hw/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
	input  logic               clk,
	input  logic               arst_n_i,

	input  logic               rd_valid_i,
	input  mem_pkg::addr_t     rd_addr_i,
	output logic               rd_ready_o,

	input  logic               wr_valid_i,
	input  mem_pkg::addr_t     wr_addr_i,
	input  mem_pkg::word_t     wr_data_i,
	input  logic               wr_byte_i,
	output logic               wr_ready_o,

	output logic               rd_resp_valid_o,
	output mem_pkg::line_t     rd_resp_data_o,
	output mem_pkg::addr_t     rd_resp_addr_o,
	input  logic               rd_resp_ready_i,

	input  logic               cfg_wr_en_i,
	input  mem_pkg::cfg_addr_t cfg_addr_i,
	input  mem_pkg::word_t     cfg_wdata_i,
	output mem_pkg::word_t     cfg_rdata_o
);
	import mem_pkg::*;

	// store port
	logic      ram_en;
	logic      ram_we;
	line_idx_t ram_idx;
	byte_en_t  ram_be;
	line_t     ram_wdata;
	line_t     ram_rdata;

	// register block side
	lat_t      latency;
	logic      rd_done;
	logic      word_wr_done;
	logic      byte_wr_done;

	mem_access_ctrl u_ctrl (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.rd_valid_i      (rd_valid_i),
		.rd_addr_i       (rd_addr_i),
		.rd_ready_o      (rd_ready_o),
		.wr_valid_i      (wr_valid_i),
		.wr_addr_i       (wr_addr_i),
		.wr_data_i       (wr_data_i),
		.wr_byte_i       (wr_byte_i),
		.wr_ready_o      (wr_ready_o),
		.rd_resp_valid_o (rd_resp_valid_o),
		.rd_resp_data_o  (rd_resp_data_o),
		.rd_resp_addr_o  (rd_resp_addr_o),
		.rd_resp_ready_i (rd_resp_ready_i),
		.ram_en_o        (ram_en),
		.ram_we_o        (ram_we),
		.ram_idx_o       (ram_idx),
		.ram_be_o        (ram_be),
		.ram_wdata_o     (ram_wdata),
		.ram_rdata_i     (ram_rdata),
		.latency_i       (latency),
		.rd_done_o       (rd_done),
		.word_wr_done_o  (word_wr_done),
		.byte_wr_done_o  (byte_wr_done)
	);

	line_ram u_ram (
		.clk     (clk),
		.en_i    (ram_en),
		.we_i    (ram_we),
		.idx_i   (ram_idx),
		.be_i    (ram_be),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	mem_cfg_regs u_regs (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.cfg_wr_en_i    (cfg_wr_en_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_wdata_i    (cfg_wdata_i),
		.cfg_rdata_o    (cfg_rdata_o),
		.latency_o      (latency),
		.rd_done_i      (rd_done),
		.word_wr_done_i (word_wr_done),
		.byte_wr_done_i (byte_wr_done)
	);

endmodule

//--- verification/mem_subsys_asserts.sv
`timescale 1ns/1ps

module mem_subsys_asserts (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  mem_pkg::ctrl_state_e state_i,
	input  logic                 rd_ready_i,
	input  logic                 wr_ready_i,
	input  logic                 rd_resp_valid_i,
	input  logic                 rd_resp_ready_i,
	input  mem_pkg::line_t       rd_resp_data_i,
	input  mem_pkg::addr_t       rd_resp_addr_i
);
	import mem_pkg::*;

	// the testbench reads this count at the end of the run
	int unsigned fail_cnt = 0;

	// a response that is not taken keeps its payload
	resp_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		rd_resp_valid_i && !rd_resp_ready_i |=>
			rd_resp_valid_i && $stable(rd_resp_data_i) && $stable(rd_resp_addr_i))
	else begin
		fail_cnt++;
		$error("pending read response changed before it was consumed");
	end

	// requests are only taken in idle
	ready_idle_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		state_i != ST_IDLE |-> !rd_ready_i && !wr_ready_i)
	else begin
		fail_cnt++;
		$error("ready output high outside the idle state");
	end

	reset_valid_a: assert property (@(posedge clk) $rose(arst_n_i) |-> !rd_resp_valid_i)
	else begin
		fail_cnt++;
		$error("read response valid right after reset release");
	end

endmodule

bind mem_access_ctrl mem_subsys_asserts u_asserts (
	.clk             (clk),
	.arst_n_i        (arst_n_i),
	.state_i         (state_q),
	.rd_ready_i      (rd_ready_o),
	.wr_ready_i      (wr_ready_o),
	.rd_resp_valid_i (rd_resp_valid_o),
	.rd_resp_ready_i (rd_resp_ready_i),
	.rd_resp_data_i  (rd_resp_data_o),
	.rd_resp_addr_i  (rd_resp_addr_o)
);

//--- verification/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;
	import mem_pkg::*;

	localparam int WAIT_LIMIT = 50;

	typedef enum {
		OP_CFG_WR,
		OP_CFG_RD,
		OP_WORD_WR,
		OP_BYTE_WR,
		OP_READ,
		OP_WR_RD
	} op_e;

	typedef struct packed {
		op_e   op;
		addr_t addr;
		word_t data;
		line_t exp;
		int    bp;
	} row_t;

	logic      clk = 1'b0;
	logic      arst_n = 1'b0;
	logic      rd_valid;
	addr_t     rd_addr;
	logic      rd_ready;
	logic      wr_valid;
	addr_t     wr_addr;
	word_t     wr_data;
	logic      wr_byte;
	logic      wr_ready;
	logic      rd_resp_valid;
	line_t     rd_resp_data;
	addr_t     rd_resp_addr;
	logic      rd_resp_ready;
	logic      cfg_wr_en;
	cfg_addr_t cfg_addr;
	word_t     cfg_wdata;
	word_t     cfg_rdata;

	row_t   rows [$];
	integer seed;
	int     cur_lat;

	mem_subsys dut (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.rd_valid_i      (rd_valid),
		.rd_addr_i       (rd_addr),
		.rd_ready_o      (rd_ready),
		.wr_valid_i      (wr_valid),
		.wr_addr_i       (wr_addr),
		.wr_data_i       (wr_data),
		.wr_byte_i       (wr_byte),
		.wr_ready_o      (wr_ready),
		.rd_resp_valid_o (rd_resp_valid),
		.rd_resp_data_o  (rd_resp_data),
		.rd_resp_addr_o  (rd_resp_addr),
		.rd_resp_ready_i (rd_resp_ready),
		.cfg_wr_en_i     (cfg_wr_en),
		.cfg_addr_i      (cfg_addr),
		.cfg_wdata_i     (cfg_wdata),
		.cfg_rdata_o     (cfg_rdata)
	);

	always #2 clk = ~clk;

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("error: %s is %h, expected %h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout: %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopping after a wait expired");
	endtask

	// every row also draws a stall count so the random sequence does not depend on the op
	task automatic add_row(input op_e op, input addr_t addr, input word_t data, input line_t exp);
		row_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		r.bp   = $unsigned($random(seed)) % 4;
		rows.push_back(r);
	endtask

	// all access tasks start on a falling edge and return on a later one
	task automatic cfg_write(input cfg_addr_t addr, input word_t data);
		cfg_wr_en = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		if (addr == REG_LATENCY) begin
			cur_lat = data[2:0];
		end
		@(negedge clk);
		cfg_wr_en = 1'b0;
	endtask

	task automatic cfg_read(input cfg_addr_t addr, input word_t exp);
		cfg_addr = addr;
		#1;
		check("cfg_rdata_o", cfg_rdata, exp);
		@(negedge clk);
	endtask

	task automatic write_access(input addr_t addr, input word_t data, input logic is_byte);
		int waited;
		wr_valid = 1'b1;
		wr_addr  = addr;
		wr_data  = data;
		wr_byte  = is_byte;
		#1;
		waited = 0;
		while (!wr_ready) begin
			if (waited >= WAIT_LIMIT) begin
				give_up("wr_ready_o stayed low while a write was pending");
			end
			@(negedge clk);
			#1;
			waited++;
		end
		@(negedge clk);
		wr_valid = 1'b0;
	endtask

	task automatic read_access(input addr_t addr, input line_t exp, input int bp);
		int    waited;
		int    lat_cycles;
		line_t held_data;
		addr_t held_addr;
		rd_valid = 1'b1;
		rd_addr  = addr;
		#1;
		waited = 0;
		while (!rd_ready) begin
			if (waited >= WAIT_LIMIT) begin
				give_up("rd_ready_o stayed low while a read was pending");
			end
			@(negedge clk);
			#1;
			waited++;
		end
		// the read is taken on the rising edge before this falling edge
		@(negedge clk);
		rd_valid      = 1'b0;
		rd_resp_ready = (bp == 0);
		#1;
		lat_cycles = 0;
		while (!rd_resp_valid) begin
			if (lat_cycles >= WAIT_LIMIT) begin
				give_up("rd_resp_valid_o never rose after an accepted read");
			end
			@(negedge clk);
			#1;
			lat_cycles++;
		end
		check("read latency in cycles", lat_cycles, 1 + cur_lat);
		check("rd_resp_data_o", rd_resp_data, exp);
		check("rd_resp_addr_o", rd_resp_addr, addr);
		check("rd_ready_o", rd_ready, 1'b0);
		check("wr_ready_o", wr_ready, 1'b0);
		held_data = rd_resp_data;
		held_addr = rd_resp_addr;
		// stalled response must not move and must block new requests
		for (int i = 1; i < bp; i++) begin
			@(negedge clk);
			#1;
			check("rd_resp_valid_o", rd_resp_valid, 1'b1);
			check("rd_resp_data_o", rd_resp_data, held_data);
			check("rd_resp_addr_o", rd_resp_addr, held_addr);
			check("rd_ready_o", rd_ready, 1'b0);
			check("wr_ready_o", wr_ready, 1'b0);
		end
		if (bp != 0) begin
			@(negedge clk);
			rd_resp_ready = 1'b1;
			#1;
			check("rd_resp_valid_o", rd_resp_valid, 1'b1);
			check("rd_resp_data_o", rd_resp_data, held_data);
			check("rd_resp_addr_o", rd_resp_addr, held_addr);
		end
		@(negedge clk);
		rd_resp_ready = 1'b0;
		#1;
		check("rd_resp_valid_o", rd_resp_valid, 1'b0);
		check("rd_ready_o", rd_ready, 1'b1);
		check("wr_ready_o", wr_ready, 1'b1);
		@(negedge clk);
	endtask

	task automatic apply_row(input row_t r);
		case (r.op)
			OP_CFG_WR:  cfg_write(cfg_addr_t'(r.addr), r.data);
			OP_CFG_RD:  cfg_read(cfg_addr_t'(r.addr), r.exp[31:0]);
			OP_WORD_WR: write_access(r.addr, r.data, 1'b0);
			OP_BYTE_WR: write_access(r.addr, r.data, 1'b1);
			OP_READ:    read_access(r.addr, r.exp, r.bp);
			OP_WR_RD: begin
				// both channels are valid in the same idle cycle and the write has to go first
				rd_valid = 1'b1;
				rd_addr  = r.addr;
				wr_valid = 1'b1;
				wr_addr  = r.addr;
				wr_data  = r.data;
				wr_byte  = 1'b0;
				#1;
				check("wr_ready_o", wr_ready, 1'b1);
				check("rd_ready_o", rd_ready, 1'b0);
				@(negedge clk);
				wr_valid = 1'b0;
				read_access(r.addr, r.exp, r.bp);
			end
			default: give_up("unknown table operation");
		endcase
	endtask

	task automatic build_table();
		add_row(OP_CFG_RD,  20'h0, 32'h0, 128'h0);
		add_row(OP_CFG_RD,  20'h1, 32'h0, 128'h0);
		add_row(OP_WORD_WR, 20'h01230, 32'h1111_aaaa, 128'h0);
		add_row(OP_WORD_WR, 20'h01234, 32'h2222_bbbb, 128'h0);
		add_row(OP_WORD_WR, 20'h01238, 32'h3333_cccc, 128'h0);
		add_row(OP_WORD_WR, 20'h0123c, 32'h4444_dddd, 128'h0);
		add_row(OP_CFG_WR,  20'h0, 32'h0, 128'h0);
		add_row(OP_READ,    20'h01230, 32'h0, 128'h4444_dddd_3333_cccc_2222_bbbb_1111_aaaa);
		// only the low data byte may land and it goes to byte 5 of the line
		add_row(OP_BYTE_WR, 20'h01235, 32'hffff_ff5a, 128'h0);
		add_row(OP_CFG_WR,  20'h0, 32'h5, 128'h0);
		add_row(OP_CFG_RD,  20'h0, 32'h0, 128'h5);
		add_row(OP_READ,    20'h01234, 32'h0, 128'h4444_dddd_3333_cccc_2222_5abb_1111_aaaa);
		add_row(OP_WORD_WR, 20'h0abc0, 32'h0102_0304, 128'h0);
		add_row(OP_WORD_WR, 20'h0abc4, 32'h0506_0708, 128'h0);
		add_row(OP_WORD_WR, 20'h0abc8, 32'h090a_0b0c, 128'h0);
		add_row(OP_WORD_WR, 20'h0abcc, 32'h0d0e_0f10, 128'h0);
		add_row(OP_BYTE_WR, 20'h0abcf, 32'h0000_0077, 128'h0);
		add_row(OP_CFG_WR,  20'h0, 32'h2, 128'h0);
		add_row(OP_READ,    20'h0abcc, 32'h0, 128'h770e_0f10_090a_0b0c_0506_0708_0102_0304);
		add_row(OP_CFG_WR,  20'h0, 32'h0, 128'h0);
		add_row(OP_WR_RD,   20'h0abc8, 32'hcafe_f00d,
			128'h770e_0f10_cafe_f00d_0506_0708_0102_0304);
		// four reads, nine word writes and two byte writes so far
		add_row(OP_CFG_RD,  20'h1, 32'h0, 128'h4);
		add_row(OP_CFG_RD,  20'h2, 32'h0, 128'h9);
		add_row(OP_CFG_RD,  20'h3, 32'h0, 128'h2);
		add_row(OP_CFG_WR,  20'h2, 32'hffff_ffff, 128'h0);
		add_row(OP_CFG_RD,  20'h2, 32'h0, 128'h0);
		add_row(OP_CFG_RD,  20'h1, 32'h0, 128'h4);
		add_row(OP_CFG_RD,  20'h3, 32'h0, 128'h2);
	endtask

	initial begin
		seed          = 32'h4999_66bc;
		cur_lat       = 0;
		arst_n        = 1'b0;
		rd_valid      = 1'b0;
		rd_addr       = '0;
		wr_valid      = 1'b0;
		wr_addr       = '0;
		wr_data       = '0;
		wr_byte       = 1'b0;
		rd_resp_ready = 1'b0;
		cfg_wr_en     = 1'b0;
		cfg_addr      = '0;
		cfg_wdata     = '0;
		build_table();

		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		#1;
		check("rd_resp_valid_o", rd_resp_valid, 1'b0);
		check("rd_ready_o", rd_ready, 1'b1);
		check("wr_ready_o", wr_ready, 1'b1);
		@(negedge clk);

		foreach (rows[i]) begin
			apply_row(rows[i]);
		end

		if (dut.u_ctrl.u_asserts.fail_cnt == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("assertion failures: %0d", dut.u_ctrl.u_asserts.fail_cnt);
			$display("RESULT: FAIL");
			$fatal(1, "bound assertions reported failures");
		end
	end

endmodule

//--- mem_subsys.f
hw/mem_pkg.sv
hw/line_ram.sv
hw/mem_access_ctrl.sv
hw/mem_cfg_regs.sv
hw/mem_subsys.sv
verification/mem_subsys_asserts.sv
verification/mem_subsys_tb.sv
